//--- hw/interval_pkg.sv
package interval_pkg;

    localparam int bank_addr_width = 6;
    localparam int bank_depth      = 64;
    localparam int value_width     = 16;
    localparam int count_width     = 8;
    localparam int total_width     = 24;

    // one interval endpoint
    typedef logic [value_width-1:0] value_t;

    typedef logic [bank_addr_width-1:0] bank_addr_t;

    // up to 128 intervals per batch
    typedef logic [count_width-1:0] count_t;

    typedef logic [total_width-1:0] total_t;

    // closed interval, lo <= hi assumed
    typedef struct packed {
        value_t lo;
        value_t hi;
    } interval_t;

    // one memory row holds two intervals
    typedef struct packed {
        interval_t even;
        interval_t odd;
    } row_t;

    typedef enum logic [2:0] {
        phase_load,
        phase_sort,
        phase_merge,
        phase_scan,
        phase_done
    } phase_t;

    typedef enum logic {
        bank_ping,
        bank_pong
    } bank_t;

endpackage

//--- hw/bank_mem.sv
`timescale 1ns/1ps

module bank_mem (
    input  logic                     clock,
    input  logic                     write_en,
    input  logic                     read_en,
    input  interval_pkg::bank_addr_t addr,
    input  interval_pkg::row_t       wdata,
    output interval_pkg::row_t       rdata
);

    interval_pkg::row_t mem [interval_pkg::bank_depth];

    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[addr] <= wdata;
        end
        // read data lands one cycle later
        if (read_en) begin
            rdata <= mem[addr];
        end
    end

    // single address port, so a phase owner may only read or write per cycle
    a_no_read_write: assert property (@(posedge clock) !(read_en && write_en));

endmodule

//--- hw/row_sorter.sv
`timescale 1ns/1ps

module row_sorter (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     start,
    input  interval_pkg::count_t     rows,
    input  interval_pkg::row_t       rdata,
    output logic                     read_en,
    output logic                     write_en,
    output interval_pkg::bank_addr_t addr,
    output interval_pkg::row_t       wdata,
    output logic                     finish
);

    typedef enum logic [1:0] {
        sort_idle,
        sort_read,
        sort_write
    } sort_state_t;

    sort_state_t state;
    logic        last_row;

    assign read_en  = (state == sort_read);
    assign write_en = (state == sort_write);
    assign last_row = (interval_pkg::count_t'(addr) + 8'd1 == rows);

    always_comb begin
        wdata = rdata;
        // equal starts keep their order
        if (rdata.odd.lo < rdata.even.lo) begin
            wdata.even = rdata.odd;
            wdata.odd  = rdata.even;
        end
    end

    always_ff @(posedge clock) begin
        finish <= 1'b0;
        if (reset) begin
            state <= sort_idle;
            addr  <= '0;
        end else begin
            case (state)
                sort_idle: begin
                    if (start) begin
                        addr  <= '0;
                        state <= sort_read;
                    end
                end
                sort_read: state <= sort_write;
                sort_write: begin
                    if (last_row) begin
                        finish <= 1'b1;
                        state  <= sort_idle;
                    end else begin
                        addr  <= addr + 1'b1;
                        state <= sort_read;
                    end
                end
                default: state <= sort_idle;
            endcase
        end
    end

    // address stays inside the loaded batch
    a_addr_in_batch: assert property (@(posedge clock) disable iff (reset)
        (read_en || write_en) |-> interval_pkg::count_t'(addr) < rows);

endmodule

//--- hw/merge_pass.sv
`timescale 1ns/1ps

module merge_pass (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     start,
    input  interval_pkg::count_t     intervals,
    input  interval_pkg::row_t       rdata,
    output logic                     read_en,
    output logic                     write_en,
    output interval_pkg::bank_addr_t read_addr,
    output interval_pkg::bank_addr_t write_addr,
    output interval_pkg::row_t       wdata,
    output interval_pkg::bank_t      src_bank,
    output interval_pkg::bank_t      result_bank,
    output logic                     finish
);

    typedef enum logic [1:0] {
        merge_idle,
        merge_pair,
        merge_emit,
        merge_capture
    } merge_state_t;

    merge_state_t              state;
    interval_pkg::bank_t       dst_bank;
    interval_pkg::count_t      width, next_width;
    interval_pkg::count_t      pair_base, run_mid, run_end, out_idx;
    interval_pkg::count_t      left_idx, left_end, right_idx, right_end, read_idx;
    interval_pkg::interval_t   left_head, right_head, out_val, fetched, write_buf;
    logic                      left_valid, right_valid;
    logic                      prime_left, prime_right, take_left, emitting;
    logic                      read_right, capture_right, capture_odd;

    assign dst_bank = (src_bank == interval_pkg::bank_ping) ?
                      interval_pkg::bank_pong : interval_pkg::bank_ping;

    // sums stay within 8 bits since a pass never starts with width >= intervals
    always_comb begin
        next_width = {width[6:0], 1'b0};
        run_mid    = pair_base + width;
        run_end    = pair_base + next_width;
        if (run_mid > intervals) begin
            run_mid = intervals;
        end
        if (run_end > intervals) begin
            run_end = intervals;
        end
    end

    assign prime_left  = !left_valid && (left_idx < left_end);
    assign prime_right = !right_valid && (right_idx < right_end);
    // tie goes to the left run
    assign take_left   = left_valid && (!right_valid || left_head.lo <= right_head.lo);
    assign emitting    = (state == merge_emit) && !prime_left && !prime_right &&
                         (left_valid || right_valid);
    assign out_val     = take_left ? left_head : right_head;
    assign fetched     = capture_odd ? rdata.odd : rdata.even;

    // priming reads first, then a refill alongside each emit
    always_comb begin
        read_en    = 1'b0;
        read_right = 1'b0;
        if (state == merge_emit) begin
            if (prime_left) begin
                read_en = 1'b1;
            end else if (prime_right) begin
                read_en    = 1'b1;
                read_right = 1'b1;
            end else if (emitting) begin
                read_right = !take_left;
                read_en    = take_left ? (left_idx < left_end) : (right_idx < right_end);
            end
        end
        read_idx = read_right ? right_idx : left_idx;
    end

    assign read_addr = read_idx[6:1];

    always_ff @(posedge clock) begin
        finish   <= 1'b0;
        write_en <= 1'b0;
        if (reset) begin
            state       <= merge_idle;
            src_bank    <= interval_pkg::bank_pong;
            result_bank <= interval_pkg::bank_pong;
            width       <= '0;
            pair_base   <= '0;
            out_idx     <= '0;
            left_valid  <= 1'b0;
            right_valid <= 1'b0;
        end else begin
            case (state)
                merge_idle: begin
                    if (start) begin
                        src_bank <= interval_pkg::bank_pong;
                        if (intervals <= 8'd2) begin
                            // the sorted row already is the whole list
                            result_bank <= interval_pkg::bank_pong;
                            finish      <= 1'b1;
                        end else begin
                            width     <= 8'd2;
                            pair_base <= '0;
                            out_idx   <= '0;
                            state     <= merge_pair;
                        end
                    end
                end
                merge_pair: begin
                    left_idx    <= pair_base;
                    left_end    <= run_mid;
                    right_idx   <= run_mid;
                    right_end   <= run_end;
                    left_valid  <= 1'b0;
                    right_valid <= 1'b0;
                    state       <= merge_emit;
                end
                merge_emit: begin
                    if (read_en) begin
                        if (read_right) begin
                            right_idx <= right_idx + 8'd1;
                        end else begin
                            left_idx <= left_idx + 8'd1;
                        end
                        capture_right <= read_right;
                        capture_odd   <= read_idx[0];
                        state         <= merge_capture;
                    end
                    if (emitting) begin
                        if (take_left) begin
                            left_valid <= 1'b0;
                        end else begin
                            right_valid <= 1'b0;
                        end
                        out_idx <= out_idx + 8'd1;
                        if (out_idx[0]) begin
                            write_en   <= 1'b1;
                            write_addr <= out_idx[6:1];
                            wdata      <= '{even: write_buf, odd: out_val};
                        end else begin
                            write_buf <= out_val;
                        end
                    end else if (!read_en) begin
                        // both runs drained
                        if (run_end == intervals) begin
                            width     <= next_width;
                            src_bank  <= dst_bank;
                            pair_base <= '0;
                            out_idx   <= '0;
                            if (next_width >= intervals) begin
                                result_bank <= dst_bank;
                                finish      <= 1'b1;
                                state       <= merge_idle;
                            end else begin
                                state <= merge_pair;
                            end
                        end else begin
                            pair_base <= run_end;
                            state     <= merge_pair;
                        end
                    end
                end
                merge_capture: begin
                    if (capture_right) begin
                        right_head  <= fetched;
                        right_valid <= 1'b1;
                    end else begin
                        left_head  <= fetched;
                        left_valid <= 1'b1;
                    end
                    state <= merge_emit;
                end
                default: state <= merge_idle;
            endcase
        end
    end

endmodule

//--- hw/interval_scan.sv
`timescale 1ns/1ps

module interval_scan (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     start,
    input  interval_pkg::count_t     intervals,
    input  interval_pkg::row_t       rdata,
    output logic                     read_en,
    output interval_pkg::bank_addr_t read_addr,
    output logic                     result_valid,
    output logic                     result_last,
    output interval_pkg::interval_t  result_interval,
    output interval_pkg::total_t     covered_total,
    output logic                     finish
);

    typedef enum logic [2:0] {
        scan_idle,
        scan_read,
        scan_even,
        scan_odd,
        scan_flush
    } scan_state_t;

    scan_state_t             state;
    interval_pkg::count_t    row;
    interval_pkg::interval_t current, incoming;
    logic                    first, touches, more_rows;

    function automatic interval_pkg::total_t span(input interval_pkg::interval_t iv);
        return interval_pkg::total_t'(iv.hi - iv.lo) + 24'd1;
    endfunction

    assign incoming  = (state == scan_odd) ? rdata.odd : rdata.even;
    // touching intervals merge too, hence the plus one
    assign touches   = ({1'b0, incoming.lo} <= {1'b0, current.hi} + 17'd1);
    assign more_rows = (row < (intervals >> 1));
    assign read_en   = (state == scan_read) || (state == scan_odd && more_rows);
    assign read_addr = row[5:0];

    always_ff @(posedge clock) begin
        result_valid <= 1'b0;
        result_last  <= 1'b0;
        finish       <= 1'b0;
        if (reset) begin
            state         <= scan_idle;
            row           <= '0;
            first         <= 1'b1;
            covered_total <= '0;
        end else begin
            case (state)
                scan_idle: begin
                    if (start) begin
                        row           <= '0;
                        first         <= 1'b1;
                        covered_total <= '0;
                        state         <= scan_read;
                    end
                end
                scan_read: state <= scan_even;
                scan_even, scan_odd: begin
                    if (first) begin
                        current <= incoming;
                        first   <= 1'b0;
                    end else if (touches) begin
                        if (incoming.hi > current.hi) begin
                            current.hi <= incoming.hi;
                        end
                    end else begin
                        result_valid    <= 1'b1;
                        result_interval <= current;
                        covered_total   <= covered_total + span(current);
                        current         <= incoming;
                    end
                    if (state == scan_even) begin
                        row   <= row + 8'd1;
                        state <= scan_odd;
                    end else begin
                        state <= more_rows ? scan_even : scan_flush;
                    end
                end
                scan_flush: begin
                    result_valid    <= 1'b1;
                    result_last     <= 1'b1;
                    result_interval <= current;
                    covered_total   <= covered_total + span(current);
                    finish          <= 1'b1;
                    state           <= scan_idle;
                end
                default: state <= scan_idle;
            endcase
        end
    end

    // merging relies on ascending starts from the merge passes
    a_sorted_input: assert property (@(posedge clock) disable iff (reset)
        (state inside {scan_even, scan_odd} && !first) |-> incoming.lo >= current.lo);

endmodule

//--- hw/interval_sorter.sv
`timescale 1ns/1ps

module interval_sorter (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     load_valid,
    input  logic                     load_done,
    input  interval_pkg::bank_addr_t load_addr,
    input  interval_pkg::row_t       load_row,
    output logic                     result_valid,
    output logic                     result_last,
    output interval_pkg::interval_t  result_interval,
    output interval_pkg::total_t     covered_total,
    output logic                     done
);

    interval_pkg::phase_t     phase;
    interval_pkg::count_t     row_count, interval_count;
    logic                     sort_start, merge_start, scan_start;

    logic                     bank_write_en [2];
    logic                     bank_read_en [2];
    interval_pkg::bank_addr_t bank_addr [2];
    interval_pkg::row_t       bank_wdata [2];
    interval_pkg::row_t       bank_rdata [2];

    logic                     sort_read_en, sort_write_en, sort_finish;
    interval_pkg::bank_addr_t sort_addr;
    interval_pkg::row_t       sort_wdata;

    logic                     merge_read_en, merge_write_en, merge_finish;
    interval_pkg::bank_addr_t merge_read_addr, merge_write_addr;
    interval_pkg::row_t       merge_wdata;
    interval_pkg::bank_t      merge_src, merge_dst, result_bank;

    logic                     scan_read_en, scan_finish;
    interval_pkg::bank_addr_t scan_read_addr;

    assign interval_count = {row_count[6:0], 1'b0};
    assign merge_dst      = (merge_src == interval_pkg::bank_ping) ?
                            interval_pkg::bank_pong : interval_pkg::bank_ping;
    assign done           = (phase == interval_pkg::phase_done);

    // bank ownership by phase
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            bank_write_en[b] = 1'b0;
            bank_read_en[b]  = 1'b0;
            bank_addr[b]     = '0;
            bank_wdata[b]    = '0;
        end
        case (phase)
            interval_pkg::phase_load: begin
                bank_write_en[interval_pkg::bank_ping] = load_valid;
                bank_addr[interval_pkg::bank_ping]     = load_addr;
                bank_wdata[interval_pkg::bank_ping]    = load_row;
            end
            interval_pkg::phase_sort: begin
                bank_read_en[interval_pkg::bank_ping]  = sort_read_en;
                bank_addr[interval_pkg::bank_ping]     = sort_addr;
                bank_write_en[interval_pkg::bank_pong] = sort_write_en;
                bank_addr[interval_pkg::bank_pong]     = sort_addr;
                bank_wdata[interval_pkg::bank_pong]    = sort_wdata;
            end
            interval_pkg::phase_merge: begin
                bank_read_en[merge_src]  = merge_read_en;
                bank_addr[merge_src]     = merge_read_addr;
                bank_write_en[merge_dst] = merge_write_en;
                bank_addr[merge_dst]     = merge_write_addr;
                bank_wdata[merge_dst]    = merge_wdata;
            end
            interval_pkg::phase_scan: begin
                bank_read_en[result_bank] = scan_read_en;
                bank_addr[result_bank]    = scan_read_addr;
            end
            default: ;
        endcase
    end

    bank_mem bank_ping (
        .clock   (clock),
        .write_en(bank_write_en[interval_pkg::bank_ping]),
        .read_en (bank_read_en[interval_pkg::bank_ping]),
        .addr    (bank_addr[interval_pkg::bank_ping]),
        .wdata   (bank_wdata[interval_pkg::bank_ping]),
        .rdata   (bank_rdata[interval_pkg::bank_ping])
    );

    bank_mem bank_pong (
        .clock   (clock),
        .write_en(bank_write_en[interval_pkg::bank_pong]),
        .read_en (bank_read_en[interval_pkg::bank_pong]),
        .addr    (bank_addr[interval_pkg::bank_pong]),
        .wdata   (bank_wdata[interval_pkg::bank_pong]),
        .rdata   (bank_rdata[interval_pkg::bank_pong])
    );

    row_sorter row_sorter_inst (
        .clock   (clock),
        .reset   (reset),
        .start   (sort_start),
        .rows    (row_count),
        .rdata   (bank_rdata[interval_pkg::bank_ping]),
        .read_en (sort_read_en),
        .write_en(sort_write_en),
        .addr    (sort_addr),
        .wdata   (sort_wdata),
        .finish  (sort_finish)
    );

    merge_pass merge_pass_inst (
        .clock      (clock),
        .reset      (reset),
        .start      (merge_start),
        .intervals  (interval_count),
        .rdata      (bank_rdata[merge_src]),
        .read_en    (merge_read_en),
        .write_en   (merge_write_en),
        .read_addr  (merge_read_addr),
        .write_addr (merge_write_addr),
        .wdata      (merge_wdata),
        .src_bank   (merge_src),
        .result_bank(result_bank),
        .finish     (merge_finish)
    );

    interval_scan interval_scan_inst (
        .clock          (clock),
        .reset          (reset),
        .start          (scan_start),
        .intervals      (interval_count),
        .rdata          (bank_rdata[result_bank]),
        .read_en        (scan_read_en),
        .read_addr      (scan_read_addr),
        .result_valid   (result_valid),
        .result_last    (result_last),
        .result_interval(result_interval),
        .covered_total  (covered_total),
        .finish         (scan_finish)
    );

    // start pulses coincide with the first cycle of each phase
    always_ff @(posedge clock) begin
        sort_start  <= 1'b0;
        merge_start <= 1'b0;
        scan_start  <= 1'b0;
        if (reset) begin
            phase     <= interval_pkg::phase_load;
            row_count <= '0;
        end else begin
            case (phase)
                interval_pkg::phase_load: begin
                    if (load_valid) begin
                        row_count <= row_count + 8'd1;
                    end
                    if (load_done) begin
                        phase      <= interval_pkg::phase_sort;
                        sort_start <= 1'b1;
                    end
                end
                interval_pkg::phase_sort: begin
                    if (sort_finish) begin
                        phase       <= interval_pkg::phase_merge;
                        merge_start <= 1'b1;
                    end
                end
                interval_pkg::phase_merge: begin
                    if (merge_finish) begin
                        phase      <= interval_pkg::phase_scan;
                        scan_start <= 1'b1;
                    end
                end
                interval_pkg::phase_scan: begin
                    if (scan_finish) begin
                        phase <= interval_pkg::phase_done;
                    end
                end
                default: ;
            endcase
        end
    end

    // one to 64 rows per batch
    a_batch_size: assert property (@(posedge clock) disable iff (reset)
        (load_done && phase == interval_pkg::phase_load)
        |-> (row_count + {7'd0, load_valid}) inside {[8'd1:8'd64]});

endmodule

//--- sim/interval_sorter_tb.sv
`timescale 1ns/1ps

module interval_sorter_tb;

    localparam int done_timeout = 5000;

    logic                     clock = 1'b0;
    logic                     reset;
    logic                     load_valid;
    logic                     load_done;
    interval_pkg::bank_addr_t load_addr;
    interval_pkg::row_t       load_row;
    logic                     result_valid;
    logic                     result_last;
    interval_pkg::interval_t  result_interval;
    interval_pkg::total_t     covered_total;
    logic                     done;

    interval_pkg::interval_t  batch [128];
    interval_pkg::interval_t  expected [$];
    int                       expected_total;
    int                       got_count;
    interval_pkg::value_t     prev_hi;
    int                       mismatch_count = 0;
    int                       failure_count = 0;
    logic                     aborted = 1'b0;
    logic [31:0]              lfsr_state = 32'h9405_a147;

    interval_sorter interval_sorter_inst (
        .clock          (clock),
        .reset          (reset),
        .load_valid     (load_valid),
        .load_done      (load_done),
        .load_addr      (load_addr),
        .load_row       (load_row),
        .result_valid   (result_valid),
        .result_last    (result_last),
        .result_interval(result_interval),
        .covered_total  (covered_total),
        .done           (done)
    );

    always #50 clock = ~clock;

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [15:0] random_bits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsr_bit()};
        end
        return value;
    endfunction

    // narrow bit counts crowd the intervals so they overlap
    task automatic fill_random(input int rows, input int bits);
        logic [15:0] a;
        logic [15:0] b;
        for (int i = 0; i < 2 * rows; i++) begin
            a = random_bits(bits);
            b = random_bits(bits);
            batch[i].lo = (a <= b) ? a : b;
            batch[i].hi = (a <= b) ? b : a;
        end
    endtask

    // insertion sort by lo, then join overlapping or touching neighbours
    task automatic build_expected(input int count);
        interval_pkg::interval_t sorted [128];
        interval_pkg::interval_t key;
        interval_pkg::interval_t current;
        int j;
        for (int i = 0; i < count; i++) begin
            sorted[i] = batch[i];
        end
        for (int i = 1; i < count; i++) begin
            key = sorted[i];
            j = i - 1;
            while (j >= 0 && sorted[j].lo > key.lo) begin
                sorted[j + 1] = sorted[j];
                j--;
            end
            sorted[j + 1] = key;
        end
        expected.delete();
        expected_total = 0;
        current = sorted[0];
        for (int i = 1; i < count; i++) begin
            if (int'(sorted[i].lo) <= int'(current.hi) + 1) begin
                if (sorted[i].hi > current.hi) begin
                    current.hi = sorted[i].hi;
                end
            end else begin
                expected.push_back(current);
                expected_total += int'(current.hi) - int'(current.lo) + 1;
                current = sorted[i];
            end
        end
        expected.push_back(current);
        expected_total += int'(current.hi) - int'(current.lo) + 1;
    endtask

    task automatic apply_reset();
        @(posedge clock);
        reset      <= 1'b1;
        load_valid <= 1'b0;
        load_done  <= 1'b0;
        @(posedge clock);
        @(negedge clock);
        assert (!result_valid && !result_last && !done && covered_total == '0) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: outputs not cleared one cycle into reset", $time);
        end
        got_count = 0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic load_rows(input int rows);
        for (int r = 0; r < rows; r++) begin
            @(posedge clock);
            load_valid <= 1'b1;
            load_addr  <= interval_pkg::bank_addr_t'(r);
            load_row   <= '{even: batch[2 * r], odd: batch[2 * r + 1]};
        end
        @(posedge clock);
        load_valid <= 1'b0;
        load_done  <= 1'b1;
        @(posedge clock);
        load_done <= 1'b0;
    endtask

    task automatic run_batch(input int rows);
        int cycles;
        if (aborted) begin
            return;
        end
        apply_reset();
        build_expected(2 * rows);
        load_rows(rows);
        cycles = 0;
        @(negedge clock);
        while (done !== 1'b1 && cycles < done_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (done !== 1'b1) begin
            failure_count++;
            $display("timeout: done did not rise for a batch of %0d rows", rows);
            aborted = 1'b1;
            return;
        end
        assert (covered_total == interval_pkg::total_t'(expected_total)) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: covered_total %0d, expected %0d",
                     $time, covered_total, expected_total);
        end
        assert (got_count == expected.size()) else begin
            mismatch_count++;
            $display("MISMATCH at %0t: %0d results, expected %0d",
                     $time, got_count, expected.size());
        end
        repeat (3) begin
            @(negedge clock);
            assert (done && !result_valid) else begin
                mismatch_count++;
                $display("MISMATCH at %0t: activity after done", $time);
            end
        end
    endtask

    task automatic reset_mid_batch();
        int cycles;
        if (aborted) begin
            return;
        end
        fill_random(48, 16);
        apply_reset();
        build_expected(96);
        load_rows(48);
        cycles = 0;
        @(negedge clock);
        while (result_valid !== 1'b1 && cycles < done_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (result_valid !== 1'b1) begin
            failure_count++;
            $display("timeout: no result appeared before the mid-batch reset");
            aborted = 1'b1;
            return;
        end
        apply_reset();
    endtask

    // result stream against the model
    always @(negedge clock) begin
        if (!reset && result_valid === 1'b1) begin
            if (got_count >= expected.size()) begin
                failure_count++;
                $display("more results than the model produced, extra one at %0t", $time);
            end else begin
                assert (result_interval == expected[got_count]) else begin
                    mismatch_count++;
                    $display("MISMATCH at %0t: result %0d is [%0d,%0d], expected [%0d,%0d]",
                             $time, got_count, result_interval.lo, result_interval.hi,
                             expected[got_count].lo, expected[got_count].hi);
                end
                assert (result_last == (got_count == expected.size() - 1)) else begin
                    mismatch_count++;
                    $display("MISMATCH at %0t: result_last %0b on result %0d of %0d",
                             $time, result_last, got_count, expected.size());
                end
            end
            if (got_count > 0) begin
                assert ({1'b0, result_interval.lo} > {1'b0, prev_hi} + 17'd1) else begin
                    mismatch_count++;
                    $display("MISMATCH at %0t: lo %0d not separated from previous hi %0d",
                             $time, result_interval.lo, prev_hi);
                end
            end
            prev_hi = result_interval.hi;
            got_count++;
        end
    end

    reset_clears: assert property (@(posedge clock)
        reset |=> !result_valid && !result_last && !done && covered_total == '0)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: outputs not cleared by reset", $time);
        end

    done_holds: assert property (@(posedge clock) disable iff (reset) done |=> done)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: done dropped without reset", $time);
        end

    quiet_when_done: assert property (@(posedge clock) disable iff (reset)
        done |-> !result_valid)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: result_valid while done", $time);
        end

    last_with_valid: assert property (@(posedge clock) disable iff (reset)
        result_last |-> result_valid)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: result_last without result_valid", $time);
        end

    initial begin
        int rows;
        reset      = 1'b1;
        load_valid = 1'b0;
        load_done  = 1'b0;
        load_addr  = '0;
        load_row   = '0;

        // single row, swapped and in order
        batch[0] = '{lo: 16'd10, hi: 16'd20};
        batch[1] = '{lo: 16'd3, hi: 16'd5};
        run_batch(1);
        batch[0] = '{lo: 16'd3, hi: 16'd5};
        batch[1] = '{lo: 16'd10, hi: 16'd20};
        run_batch(1);

        for (int i = 0; i < 16; i++) begin
            batch[i] = '{lo: 16'd100, hi: 16'd200};
        end
        run_batch(8);

        // touching intervals in reverse order, ten of them
        for (int i = 0; i < 10; i++) begin
            batch[i].lo = interval_pkg::value_t'(10 * (9 - i));
            batch[i].hi = interval_pkg::value_t'(10 * (9 - i) + 9);
        end
        run_batch(5);

        fill_random(3, 6);
        run_batch(3);
        fill_random(7, 8);
        run_batch(7);
        fill_random(64, 16);
        run_batch(64);
        fill_random(64, 7);
        run_batch(64);

        for (int b = 0; b < 8; b++) begin
            rows = 1 + int'(random_bits(6));
            fill_random(rows, b[0] ? 16 : 6);
            run_batch(rows);
        end

        reset_mid_batch();
        fill_random(20, 8);
        run_batch(20);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
hw/interval_pkg.sv
hw/bank_mem.sv
hw/row_sorter.sv
hw/merge_pass.sv
hw/interval_scan.sv
hw/interval_sorter.sv
sim/interval_sorter_tb.sv
